// File: Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
RTL_TOP ?= cpuTop
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5; // 32 registers
	localparam int constWidth = 15;
	localparam int opcodeWidth = 6;
	localparam int aluOpWidth = 4;

	// instruction field positions
	localparam int opcodeLsb = 26;
	localparam int rsLsb = 20;
	localparam int rtLsb = 15;
	localparam int rdLsb = 10;

	localparam int luiShift = 17; // 15-bit constant lands in the top bits

	typedef enum logic [opcodeWidth-1:0] {
		opHalt = 6'd0,
		opAlu = 6'd1,
		opAddi = 6'd2,
		opLui = 6'd3,
		opLw = 6'd4,
		opSw = 6'd5
	} opcodeT;

	typedef enum logic [aluOpWidth-1:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr = 4'd3,
		aluXor = 4'd4,
		aluSlt = 4'd5
	} aluOpT;

	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdExec = 2'd1,
		fwdMem = 2'd2,
		fwdWb = 2'd3
	} fwdSelT;

endpackage

`default_nettype wire

// File: hw/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
	parameter int imemAddrWidth = 6,
	parameter int dmemAddrWidth = 6
) (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [imemAddrWidth-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic cpuDone
);

	// fetch to decode
	logic [cpuPkg::dataWidth-1:0] instrD;
	logic validD;

	// decode side
	logic [cpuPkg::regAddrWidth-1:0] rsAddr, rtAddr;
	logic [cpuPkg::dataWidth-1:0] rsData, rtData;
	logic useRs, useRt, stall;
	cpuPkg::fwdSelT fwdSelA, fwdSelB;

	// decode to execute
	cpuPkg::opcodeT opE;
	cpuPkg::aluOpT aluOpE;
	logic [cpuPkg::regAddrWidth-1:0] destE;
	logic writeEnE, isLoadE, isStoreE, haltE;
	logic [cpuPkg::dataWidth-1:0] operandAE, operandBE, storeDataE, execResult;
	logic [cpuPkg::constWidth-1:0] immE;

	// execute to memory
	logic [cpuPkg::dataWidth-1:0] aluResultM, storeDataM, memResult;
	logic [cpuPkg::regAddrWidth-1:0] destM;
	logic writeEnM, isLoadM, isStoreM, haltM;

	fetchStage #(.imemAddrWidth(imemAddrWidth)) i_fetch (
		.clk(clk), .reset(reset), .stall(stall),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.instrD(instrD), .validD(validD)
	);

	regFile i_regFile (
		.clk(clk), .reset(reset),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
		.writeEn(wbValid), .writeAddr(wbReg), .writeData(wbData)
	);

	decodeStage i_decode (
		.clk(clk), .reset(reset), .instrD(instrD), .validD(validD),
		.rsData(rsData), .rtData(rtData), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.useRs(useRs), .useRt(useRt),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .stall(stall),
		.execResult(execResult), .memResult(memResult), .wbData(wbData),
		.opE(opE), .aluOpE(aluOpE), .destE(destE), .writeEnE(writeEnE),
		.isLoadE(isLoadE), .isStoreE(isStoreE), .haltE(haltE),
		.operandAE(operandAE), .operandBE(operandBE), .storeDataE(storeDataE), .immE(immE)
	);

	hazardUnit i_hazard (
		.rsAddr(rsAddr), .rtAddr(rtAddr), .useRs(useRs), .useRt(useRt),
		.destE(destE), .writeEnE(writeEnE), .isLoadE(isLoadE),
		.destM(destM), .writeEnM(writeEnM), .wbReg(wbReg), .wbValid(wbValid),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .stall(stall)
	);

	executeStage i_execute (
		.clk(clk), .reset(reset),
		.opE(opE), .aluOpE(aluOpE), .destE(destE), .writeEnE(writeEnE),
		.isLoadE(isLoadE), .isStoreE(isStoreE), .haltE(haltE),
		.operandAE(operandAE), .operandBE(operandBE), .storeDataE(storeDataE), .immE(immE),
		.execResult(execResult), .aluResultM(aluResultM), .storeDataM(storeDataM),
		.destM(destM), .writeEnM(writeEnM), .isLoadM(isLoadM), .isStoreM(isStoreM),
		.haltM(haltM)
	);

	memoryStage #(.dmemAddrWidth(dmemAddrWidth)) i_memory (
		.clk(clk), .reset(reset),
		.aluResultM(aluResultM), .storeDataM(storeDataM), .destM(destM),
		.writeEnM(writeEnM), .isLoadM(isLoadM), .isStoreM(isStoreM), .haltM(haltM),
		.memResult(memResult), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.cpuDone(cpuDone)
	);

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::dataWidth-1:0] instrD,
	input logic validD,
	input logic [cpuPkg::dataWidth-1:0] rsData,
	input logic [cpuPkg::dataWidth-1:0] rtData,
	output logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	output logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	output logic useRs,
	output logic useRt,
	input cpuPkg::fwdSelT fwdSelA,
	input cpuPkg::fwdSelT fwdSelB,
	input logic stall,
	input logic [cpuPkg::dataWidth-1:0] execResult,
	input logic [cpuPkg::dataWidth-1:0] memResult,
	input logic [cpuPkg::dataWidth-1:0] wbData,
	output cpuPkg::opcodeT opE,
	output cpuPkg::aluOpT aluOpE,
	output logic [cpuPkg::regAddrWidth-1:0] destE,
	output logic writeEnE,
	output logic isLoadE,
	output logic isStoreE,
	output logic haltE,
	output logic [cpuPkg::dataWidth-1:0] operandAE,
	output logic [cpuPkg::dataWidth-1:0] operandBE,
	output logic [cpuPkg::dataWidth-1:0] storeDataE,
	output logic [cpuPkg::constWidth-1:0] immE
);

	cpuPkg::opcodeT opD;
	cpuPkg::aluOpT aluOpD;
	logic [cpuPkg::regAddrWidth-1:0] rdD, destD;
	logic writeEnD, isLoadD, isStoreD, haltD;
	logic [cpuPkg::dataWidth-1:0] fwdA, fwdB;

	function automatic logic [cpuPkg::dataWidth-1:0] fwdMux(
		input cpuPkg::fwdSelT sel,
		input logic [cpuPkg::dataWidth-1:0] regVal,
		input logic [cpuPkg::dataWidth-1:0] execVal,
		input logic [cpuPkg::dataWidth-1:0] memVal,
		input logic [cpuPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			cpuPkg::fwdExec: fwdMux = execVal;
			cpuPkg::fwdMem: fwdMux = memVal;
			cpuPkg::fwdWb: fwdMux = wbVal;
			default: fwdMux = regVal;
		endcase
	endfunction

	// field split
	assign opD = cpuPkg::opcodeT'(instrD[cpuPkg::opcodeLsb +: cpuPkg::opcodeWidth]);
	assign rsAddr = instrD[cpuPkg::rsLsb +: cpuPkg::regAddrWidth];
	assign rtAddr = instrD[cpuPkg::rtLsb +: cpuPkg::regAddrWidth];
	assign rdD = instrD[cpuPkg::rdLsb +: cpuPkg::regAddrWidth];

	always_comb begin
		aluOpD = cpuPkg::aluAdd; // immediates and addresses all add
		destD = rtAddr;
		writeEnD = 1'b0;
		isLoadD = 1'b0;
		isStoreD = 1'b0;
		haltD = 1'b0;
		useRs = 1'b0;
		useRt = 1'b0;
		if (validD) begin
			case (opD)
				cpuPkg::opAlu: begin
					aluOpD = cpuPkg::aluOpT'(instrD[cpuPkg::aluOpWidth-1:0]);
					destD = rdD;
					writeEnD = 1'b1;
					useRs = 1'b1;
					useRt = 1'b1;
				end
				cpuPkg::opAddi: begin
					writeEnD = 1'b1;
					useRs = 1'b1;
				end
				cpuPkg::opLui: writeEnD = 1'b1; // no register source
				cpuPkg::opLw: begin
					writeEnD = 1'b1;
					isLoadD = 1'b1;
					useRs = 1'b1;
				end
				cpuPkg::opSw: begin
					isStoreD = 1'b1;
					useRs = 1'b1;
					useRt = 1'b1; // store data
				end
				cpuPkg::opHalt: haltD = 1'b1;
				default: ; // unknown opcodes pass as no-ops
			endcase
		end
	end

	assign fwdA = fwdMux(fwdSelA, rsData, execResult, memResult, wbData);
	assign fwdB = fwdMux(fwdSelB, rtData, execResult, memResult, wbData);

	// bubble on stall while fetch holds the instruction
	always_ff @(posedge clk) begin
		if (reset || stall) begin
			writeEnE <= 1'b0;
			isLoadE <= 1'b0;
			isStoreE <= 1'b0;
			haltE <= 1'b0;
		end else begin
			writeEnE <= writeEnD;
			isLoadE <= isLoadD;
			isStoreE <= isStoreD;
			haltE <= haltD;
		end
	end

	always_ff @(posedge clk) begin
		opE <= opD;
		aluOpE <= aluOpD;
		destE <= destD;
		operandAE <= fwdA;
		operandBE <= fwdB;
		storeDataE <= fwdB;
		immE <= instrD[cpuPkg::constWidth-1:0];
	end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::opcodeT opE,
	input cpuPkg::aluOpT aluOpE,
	input logic [cpuPkg::regAddrWidth-1:0] destE,
	input logic writeEnE,
	input logic isLoadE,
	input logic isStoreE,
	input logic haltE,
	input logic [cpuPkg::dataWidth-1:0] operandAE,
	input logic [cpuPkg::dataWidth-1:0] operandBE,
	input logic [cpuPkg::dataWidth-1:0] storeDataE,
	input logic [cpuPkg::constWidth-1:0] immE,
	output logic [cpuPkg::dataWidth-1:0] execResult,
	output logic [cpuPkg::dataWidth-1:0] aluResultM,
	output logic [cpuPkg::dataWidth-1:0] storeDataM,
	output logic [cpuPkg::regAddrWidth-1:0] destM,
	output logic writeEnM,
	output logic isLoadM,
	output logic isStoreM,
	output logic haltM
);

	logic [cpuPkg::dataWidth-1:0] immExt, aluA, aluB;

	assign immExt = {{(cpuPkg::dataWidth-cpuPkg::constWidth){immE[cpuPkg::constWidth-1]}}, immE};

	// operand select
	always_comb begin
		case (opE)
			cpuPkg::opAlu: begin
				aluA = operandAE;
				aluB = operandBE;
			end
			cpuPkg::opLui: begin
				aluA = '0; // add to zero
				aluB = cpuPkg::dataWidth'(immE) << cpuPkg::luiShift;
			end
			default: begin
				aluA = operandAE;
				aluB = immExt;
			end
		endcase
	end

	always_comb begin
		case (aluOpE)
			cpuPkg::aluAdd: execResult = aluA + aluB;
			cpuPkg::aluSub: execResult = aluA - aluB;
			cpuPkg::aluAnd: execResult = aluA & aluB;
			cpuPkg::aluOr: execResult = aluA | aluB;
			cpuPkg::aluXor: execResult = aluA ^ aluB;
			cpuPkg::aluSlt: execResult = {{(cpuPkg::dataWidth-1){1'b0}}, $signed(aluA) < $signed(aluB)};
			default: execResult = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			writeEnM <= 1'b0;
			isLoadM <= 1'b0;
			isStoreM <= 1'b0;
			haltM <= 1'b0;
		end else begin
			writeEnM <= writeEnE;
			isLoadM <= isLoadE;
			isStoreM <= isStoreE;
			haltM <= haltE;
		end
	end

	always_ff @(posedge clk) begin
		aluResultM <= execResult; // also the memory address
		storeDataM <= storeDataE;
		destM <= destE;
	end

endmodule

`default_nettype wire

// File: hw/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
	parameter int imemAddrWidth = 6
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic progWrite,
	input logic [imemAddrWidth-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	output logic [cpuPkg::dataWidth-1:0] instrD,
	output logic validD
);

	logic [cpuPkg::dataWidth-1:0] imem [2**imemAddrWidth];
	logic [cpuPkg::dataWidth-1:0] instrF;
	logic [imemAddrWidth-1:0] pc;
	logic halted; // halt word already sent down
	logic haltF;

	assign instrF = imem[pc];
	assign haltF = instrF[cpuPkg::opcodeLsb +: cpuPkg::opcodeWidth] == cpuPkg::opHalt;

	// program load, only while the core sits in reset
	always_ff @(posedge clk) begin
		if (reset && progWrite) begin
			imem[progAddr] <= progData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			halted <= 1'b0;
			validD <= 1'b0;
		end else if (!stall) begin
			validD <= !halted; // halt itself goes down once as valid
			if (!halted) begin
				if (haltF) begin
					halted <= 1'b1; // pc parks here
				end else begin
					pc <= pc + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !halted) begin
			instrD <= instrF;
		end
	end

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	input logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	input logic useRs,
	input logic useRt,
	input logic [cpuPkg::regAddrWidth-1:0] destE,
	input logic writeEnE,
	input logic isLoadE,
	input logic [cpuPkg::regAddrWidth-1:0] destM,
	input logic writeEnM,
	input logic [cpuPkg::regAddrWidth-1:0] wbReg,
	input logic wbValid,
	output cpuPkg::fwdSelT fwdSelA,
	output cpuPkg::fwdSelT fwdSelB,
	output logic stall
);

	// youngest writer wins
	function automatic cpuPkg::fwdSelT pickSource(
		input logic [cpuPkg::regAddrWidth-1:0] src,
		input logic [cpuPkg::regAddrWidth-1:0] dE,
		input logic weE,
		input logic [cpuPkg::regAddrWidth-1:0] dM,
		input logic weM,
		input logic [cpuPkg::regAddrWidth-1:0] dW,
		input logic weW
	);
		if (weE && dE == src) begin
			pickSource = cpuPkg::fwdExec;
		end else if (weM && dM == src) begin
			pickSource = cpuPkg::fwdMem;
		end else if (weW && dW == src) begin
			pickSource = cpuPkg::fwdWb;
		end else begin
			pickSource = cpuPkg::fwdReg;
		end
	endfunction

	assign fwdSelA = pickSource(rsAddr, destE, writeEnE, destM, writeEnM, wbReg, wbValid);
	assign fwdSelB = pickSource(rtAddr, destE, writeEnE, destM, writeEnM, wbReg, wbValid);

	// load data only exists one stage later
	assign stall = isLoadE && writeEnE &&
		((useRs && rsAddr == destE) || (useRt && rtAddr == destE));

endmodule

`default_nettype wire

// File: hw/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
	parameter int dmemAddrWidth = 6
) (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::dataWidth-1:0] aluResultM,
	input logic [cpuPkg::dataWidth-1:0] storeDataM,
	input logic [cpuPkg::regAddrWidth-1:0] destM,
	input logic writeEnM,
	input logic isLoadM,
	input logic isStoreM,
	input logic haltM,
	output logic [cpuPkg::dataWidth-1:0] memResult,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic cpuDone
);

	logic [cpuPkg::dataWidth-1:0] dmem [2**dmemAddrWidth];
	logic [dmemAddrWidth-1:0] wordAddr;

	assign wordAddr = aluResultM[2 +: dmemAddrWidth]; // byte address, word aligned

	always_ff @(posedge clk) begin
		if (isStoreM) begin
			dmem[wordAddr] <= storeDataM;
		end
	end

	// load data or alu value, also the mem-distance forward
	assign memResult = isLoadM ? dmem[wordAddr] : aluResultM;

	always_ff @(posedge clk) begin
		if (reset) begin
			wbValid <= 1'b0;
			cpuDone <= 1'b0;
		end else begin
			wbValid <= writeEnM;
			if (haltM) begin
				cpuDone <= 1'b1; // sticky until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= destM;
		wbData <= memResult;
	end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	input logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	output logic [cpuPkg::dataWidth-1:0] rsData,
	output logic [cpuPkg::dataWidth-1:0] rtData,
	input logic writeEn,
	input logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	input logic [cpuPkg::dataWidth-1:0] writeData
);

	// r0 is writable like the rest
	logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regAddrWidth];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign rsData = regs[rsAddr]; // same-cycle write is covered by wb forwarding
	assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

// File: src.f
hw/cpuPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/cpuTop.sv
verification/cpuTop_sva.sv
verification/cpuChecker.sv
verification/cpuTb.sv

// File: verification/cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuChecker (
	input logic clk,
	input logic reset,
	input logic wbValid,
	input logic [cpuPkg::regAddrWidth-1:0] wbReg,
	input logic [cpuPkg::dataWidth-1:0] wbData,
	input logic cpuDone
);

	int errorCount = 0;
	int checkCount = 0;
	int writeIndex = 0;
	logic doneSeen = 1'b0;

	// expected write trace, program order
	int expTest [$];
	logic [cpuPkg::regAddrWidth-1:0] expReg [$];
	logic [cpuPkg::dataWidth-1:0] expData [$];

	function automatic string testName(input int id);
		case (id)
			1: testName = "addImmediate";
			2: testName = "aluForwarding";
			3: testName = "loadUpper";
			4: testName = "storeLoad";
			5: testName = "loadUseStall";
			default: testName = "unnamed";
		endcase
	endfunction

	task automatic expectWrite(
		input int test,
		input logic [cpuPkg::regAddrWidth-1:0] r,
		input logic [cpuPkg::dataWidth-1:0] d
	);
		expTest.push_back(test);
		expReg.push_back(r);
		expData.push_back(d);
	endtask

	task automatic compareWrite();
		int test;
		logic [cpuPkg::regAddrWidth-1:0] r;
		logic [cpuPkg::dataWidth-1:0] d;
		test = expTest.pop_front();
		r = expReg.pop_front();
		d = expData.pop_front();
		checkCount++;
		if (wbReg !== r || wbData !== d) begin
			errorCount++;
			$display("ERROR %s write %0d: expected r%0d=%h actual r%0d=%h",
				testName(test), writeIndex, r, d, wbReg, wbData);
		end
		writeIndex++;
	endtask

	// outputs settle after the rising edge, sample on the falling one
	always @(negedge clk) begin
		if (!reset) begin
			if (wbValid === 1'b1) begin
				if (doneSeen) begin
					errorCount++;
					$display("register r%0d was written after cpuDone had risen", wbReg);
				end else if (expTest.size() == 0) begin
					errorCount++;
					$display("unexpected write to r%0d, the trace has no writes left", wbReg);
				end else begin
					compareWrite();
				end
			end
			if (cpuDone === 1'b1 && !doneSeen) begin
				doneSeen = 1'b1;
				if (expTest.size() != 0) begin
					errorCount++;
					$display("cpuDone rose with %0d expected writes still missing",
						expTest.size());
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int imemAddrWidth = 6;
	localparam int dmemAddrWidth = 6;
	localparam int clkPeriod = 4;
	localparam int resetCycles = 10;
	localparam int cyclesPerWord = 20; // watchdog budget
	localparam int drainCycles = 8; // longer than the pipeline
	localparam string goldenFile = "verification/program_golden.txt";

	logic clk;
	logic reset;
	logic progWrite;
	logic [imemAddrWidth-1:0] progAddr;
	logic [cpuPkg::dataWidth-1:0] progData;
	logic wbValid;
	logic [cpuPkg::regAddrWidth-1:0] wbReg;
	logic [cpuPkg::dataWidth-1:0] wbData;
	logic cpuDone;

	logic [31:0] golden [256];
	int progLen;
	int expCount;
	int limitCycles = 0;

	cpuTop #(
		.imemAddrWidth(imemAddrWidth),
		.dmemAddrWidth(dmemAddrWidth)
	) i_dut (
		.clk(clk), .reset(reset),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .cpuDone(cpuDone)
	);

	cpuChecker i_checker (
		.clk(clk), .reset(reset),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .cpuDone(cpuDone)
	);

	bind cpuTop cpuTop_sva i_sva (
		.clk(clk), .reset(reset), .wbValid(wbValid), .cpuDone(cpuDone)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	// header sane and last trace entry present
	function automatic bit goldenOk();
		int last;
		last = 2 + progLen + 3 * expCount - 1;
		goldenOk = progLen > 0 && progLen <= 2**imemAddrWidth && expCount > 0 &&
			last < 256 && !$isunknown(golden[last]);
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < progLen; i++) begin
			@(negedge clk);
			progWrite = 1'b1;
			progAddr = imemAddrWidth'(i);
			progData = golden[2 + i];
		end
		@(negedge clk);
		progWrite = 1'b0;
	endtask

	task automatic queueExpected();
		int idx;
		for (int k = 0; k < expCount; k++) begin
			idx = 2 + progLen + 3 * k; // test id, register, value
			i_checker.expectWrite(int'(golden[idx]),
				cpuPkg::regAddrWidth'(golden[idx + 1]), golden[idx + 2]);
		end
	endtask

	initial begin
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		$readmemh(goldenFile, golden);
		progLen = golden[0];
		expCount = golden[1];
		if (!goldenOk()) begin
			$display("golden file %s is missing or malformed", goldenFile);
			$display("RESULT: FAIL");
			$finish;
		end else begin
			limitCycles = progLen + 1 + resetCycles + progLen * cyclesPerWord;
			queueExpected();
			loadProgram(); // reset stays high through the load
			repeat (resetCycles) @(negedge clk);
			reset = 1'b0;
			while (cpuDone !== 1'b1) @(negedge clk);
			repeat (drainCycles) @(negedge clk); // catch stray writes after halt
			$display("checked %0d writes, %0d errors, %0d assertion failures",
				i_checker.checkCount, i_checker.errorCount, i_dut.i_sva.failCount);
			if (i_checker.errorCount == 0 && i_dut.i_sva.failCount == 0) begin
				$display("RESULT: PASS");
			end else begin
				$display("RESULT: FAIL");
			end
			$finish;
		end
	end

	initial begin
		wait (limitCycles != 0);
		#(limitCycles * clkPeriod);
		$display("timeout: cpuDone did not rise within %0d cycles, %0d writes checked",
			limitCycles, i_checker.checkCount);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/cpuTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_sva (
	input logic clk,
	input logic reset,
	input logic wbValid,
	input logic cpuDone
);

	int failCount = 0; // failed assertions so far

	// sync reset clears the strobe one edge later
	wbQuietInReset: assert property (@(posedge clk) reset |=> !wbValid)
		else begin
			failCount++;
			$error("wbValid high while the core is held in reset");
		end

	// sticky done flag
	doneHolds: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> !$fell(cpuDone))
		else begin
			failCount++;
			$error("cpuDone fell without a reset");
		end

	noWriteAfterDone: assert property (@(posedge clk) disable iff (reset)
		cpuDone |-> !wbValid)
		else begin
			failCount++;
			$error("register write seen after cpuDone");
		end

endmodule

`default_nettype wire

// File: verification/program_golden.txt
// word 0: program length, word 1: number of expected writes (hex)
// then one instruction per line, then expected writes as: test id, register, value
// test ids: 1 addImmediate, 2 aluForwarding, 3 loadUpper, 4 storeLoad, 5 loadUseStall
12
0f
08009234 // addi r1, r0, 0x1234
08017f00 // addi r2, r0, -256
04110c00 // add r3, r1, r2
04111001 // sub r4, r1, r2
04311402 // and r5, r3, r2
04229803 // or r6, r2, r5
04609c04 // xor r7, r6, r1
0420a005 // slt r8, r2, r1
04112405 // slt r9, r1, r2
0c051abc // lui r10, 0x1abc
08a580ff // addi r11, r10, 0xff
14058008 // sw r11, 8(r0)
10060008 // lw r12, 8(r0)
04c0b400 // add r13, r12, r1
14068010 // sw r13, 16(r0)
10070010 // lw r14, 16(r0)
08e78001 // addi r15, r14, 1
00000000 // halt
1 01 00001234
1 02 ffffff00
2 03 00001134
2 04 00001334
2 05 00001100
2 06 ffffff00
2 07 ffffed34
2 08 00000001
2 09 00000000
3 0a 35780000
3 0b 357800ff
4 0c 357800ff
5 0d 35781333
4 0e 35781333
5 0f 35781334
